//--- verilog/div_cfg_pkg.sv
package div_cfg_pkg;

	// Numerator and quotient share one width
	localparam int numer_width = 32;

	// Denominator and remainder share one width
	localparam int denom_width = 32;

	// Iteration counter, wide enough to count numer_width steps
	localparam int count_width = $clog2(numer_width + 1);

endpackage

//--- verilog/div_regs_pkg.sv
package div_regs_pkg;

	localparam int addr_width = 3;
	localparam int data_width = 32;

	// Register map
	localparam logic [addr_width-1:0] addr_numer  = 3'd0;
	localparam logic [addr_width-1:0] addr_denom  = 3'd1;
	localparam logic [addr_width-1:0] addr_ctrl   = 3'd2;
	localparam logic [addr_width-1:0] addr_status = 3'd3;
	localparam logic [addr_width-1:0] addr_quot   = 3'd4;
	localparam logic [addr_width-1:0] addr_rem    = 3'd5;

	// Bit positions in the status register
	localparam int stat_busy = 0;
	localparam int stat_done = 1;

endpackage

//--- verilog/div_reg_block.sv
`timescale 1ns/100ps

module div_reg_block (
	input  logic                                  clk,
	input  logic                                  clr,
	input  logic                                  wr_en,
	input  logic [div_regs_pkg::addr_width-1:0]   addr,
	input  logic [div_regs_pkg::data_width-1:0]   wdata,
	output logic [div_regs_pkg::data_width-1:0]   rdata,
	output logic                                  start,
	output logic [div_cfg_pkg::numer_width-1:0]   numer,
	output logic [div_cfg_pkg::denom_width-1:0]   denom,
	input  logic [div_cfg_pkg::numer_width-1:0]   quot,
	input  logic [div_cfg_pkg::denom_width-1:0]   rem,
	input  logic                                  done,
	output logic                                  busy,
	output logic                                  done_flag
);

	logic                                 start_req;
	logic [div_cfg_pkg::numer_width-1:0]  quot_r;
	logic [div_cfg_pkg::denom_width-1:0]  rem_r;

	// A start request while a division runs is dropped
	assign start_req = wr_en && (addr == div_regs_pkg::addr_ctrl) && wdata[0] && !busy;

	// Operand registers
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			numer <= '0;
			denom <= '0;
		end else if (wr_en) begin
			case (addr)
				div_regs_pkg::addr_numer: begin
					numer <= wdata[div_cfg_pkg::numer_width-1:0];
				end
				div_regs_pkg::addr_denom: begin
					denom <= wdata[div_cfg_pkg::denom_width-1:0];
				end
				default: begin
				end
			endcase
		end
	end

	// Start pulse, busy and the sticky done flag
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			start     <= 1'b0;
			busy      <= 1'b0;
			done_flag <= 1'b0;
		end else begin
			start <= start_req;
			if (start_req) begin
				busy      <= 1'b1;
				done_flag <= 1'b0;
			end else if (done) begin
				busy      <= 1'b0;
				done_flag <= 1'b1;
			end
		end
	end

	// Result capture
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			quot_r <= '0;
			rem_r  <= '0;
		end else if (done) begin
			quot_r <= quot;
			rem_r  <= rem;
		end
	end

	// Unused addresses and CTRL read back as zero
	always_comb begin
		rdata = '0;
		case (addr)
			div_regs_pkg::addr_numer: begin
				rdata[div_cfg_pkg::numer_width-1:0] = numer;
			end
			div_regs_pkg::addr_denom: begin
				rdata[div_cfg_pkg::denom_width-1:0] = denom;
			end
			div_regs_pkg::addr_status: begin
				rdata[div_regs_pkg::stat_busy] = busy;
				rdata[div_regs_pkg::stat_done] = done_flag;
			end
			div_regs_pkg::addr_quot: begin
				rdata[div_cfg_pkg::numer_width-1:0] = quot_r;
			end
			div_regs_pkg::addr_rem: begin
				rdata[div_cfg_pkg::denom_width-1:0] = rem_r;
			end
			default: begin
			end
		endcase
	end

endmodule

//--- verilog/nonrestore_div.sv
`timescale 1ns/100ps

module nonrestore_div #(
	parameter int numer_width = div_cfg_pkg::numer_width,
	parameter int denom_width = div_cfg_pkg::denom_width
) (
	input  logic                    clk,
	input  logic                    clr,
	input  logic                    start,
	input  logic [numer_width-1:0]  numer,
	input  logic [denom_width-1:0]  denom,
	output logic [numer_width-1:0]  quot,
	output logic [denom_width-1:0]  rem,
	output logic                    done
);

	// Grows past the package width when the core is built wider
	localparam int count_width = ($clog2(numer_width + 1) > div_cfg_pkg::count_width) ?
		$clog2(numer_width + 1) : div_cfg_pkg::count_width;

	localparam logic [3:0] s_idle    = 4'b0001;
	localparam logic [3:0] s_iterate = 4'b0010;
	localparam logic [3:0] s_correct = 4'b0100;
	localparam logic [3:0] s_output  = 4'b1000;

	logic [3:0]              state;
	logic [count_width-1:0]  count;
	logic [denom_width-1:0]  denom_r;
	logic [denom_width:0]    part_rem;
	logic [denom_width:0]    part_shift;
	logic [denom_width:0]    part_next;

	// The partial remainder and the quotient shift left as one register
	assign part_shift = {part_rem[denom_width-1:0], quot[numer_width-1]};

	// A negative partial remainder adds the divisor back, otherwise subtract it
	assign part_next = part_rem[denom_width] ? part_shift + {1'b0, denom_r} :
		part_shift - {1'b0, denom_r};

	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			state <= s_idle;
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				s_idle: begin
					if (start) begin
						count <= '0;
						state <= s_iterate;
					end
				end
				s_iterate: begin
					count <= count + 1'b1;
					if (count == count_width'(numer_width - 1)) begin
						state <= s_correct;
					end
				end
				s_correct: begin
					done  <= 1'b1;
					state <= s_output;
				end
				s_output: begin
					state <= s_idle;
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			s_idle: begin
				if (start) begin
					denom_r  <= denom;
					quot     <= numer;
					part_rem <= '0;
				end
			end
			s_iterate: begin
				part_rem <= part_next;
				// New sign clear means the subtraction fit
				quot     <= {quot[numer_width-2:0], ~part_next[denom_width]};
			end
			s_correct: begin
				if (part_rem[denom_width]) begin
					rem <= part_rem[denom_width-1:0] + denom_r;
				end else begin
					rem <= part_rem[denom_width-1:0];
				end
			end
			default: begin
			end
		endcase
	end

endmodule

//--- verilog/div_unit_top.sv
`timescale 1ns/100ps

module div_unit_top (
	input  logic                                 clk,
	input  logic                                 clr,
	input  logic                                 wr_en,
	input  logic [div_regs_pkg::addr_width-1:0]  addr,
	input  logic [div_regs_pkg::data_width-1:0]  wdata,
	output logic [div_regs_pkg::data_width-1:0]  rdata,
	output logic                                 busy,
	output logic                                 done_flag
);

	logic                                 start;
	logic                                 done;
	logic [div_cfg_pkg::numer_width-1:0]  numer;
	logic [div_cfg_pkg::denom_width-1:0]  denom;
	logic [div_cfg_pkg::numer_width-1:0]  quot;
	logic [div_cfg_pkg::denom_width-1:0]  rem;

	div_reg_block div_reg_block_i (
		.clk       (clk),
		.clr       (clr),
		.wr_en     (wr_en),
		.addr      (addr),
		.wdata     (wdata),
		.rdata     (rdata),
		.start     (start),
		.numer     (numer),
		.denom     (denom),
		.quot      (quot),
		.rem       (rem),
		.done      (done),
		.busy      (busy),
		.done_flag (done_flag)
	);

	// Core sized from the package so its ports match the register block
	nonrestore_div #(
		.numer_width (div_cfg_pkg::numer_width),
		.denom_width (div_cfg_pkg::denom_width)
	) nonrestore_div_i (
		.clk   (clk),
		.clr   (clr),
		.start (start),
		.numer (numer),
		.denom (denom),
		.quot  (quot),
		.rem   (rem),
		.done  (done)
	);

endmodule

//--- include/div_tb_tasks.svh
`ifndef DIV_TB_TASKS_SVH
`define DIV_TB_TASKS_SVH

// Called 1 ns after a rising edge, the write lands on the next edge
task automatic reg_write(input logic [div_regs_pkg::addr_width-1:0] a,
		input logic [div_regs_pkg::data_width-1:0] d);
	wr_en = 1'b1;
	addr  = a;
	wdata = d;
	@(posedge clk);
	#1;
	wr_en = 1'b0;
endtask

task automatic reg_read(input logic [div_regs_pkg::addr_width-1:0] a,
		output logic [div_regs_pkg::data_width-1:0] d);
	addr = a;
	#1;
	d = rdata;
endtask

task automatic check_value(input string name,
		input logic [div_regs_pkg::data_width-1:0] expected,
		input logic [div_regs_pkg::data_width-1:0] actual);
	if (expected !== actual) begin
		$display("[FAIL] %s: expected %h, got %h", name, expected, actual);
		$display("Test failed");
		$fatal(1);
	end
endtask

// Division by zero gives all ones and hands the numerator back as remainder
task automatic ref_div(input logic [div_cfg_pkg::numer_width-1:0] n,
		input logic [div_cfg_pkg::denom_width-1:0] d,
		output logic [div_cfg_pkg::numer_width-1:0] q,
		output logic [div_cfg_pkg::denom_width-1:0] r);
	if (d == '0) begin
		q = '1;
		r = n;
	end else begin
		q = n / d;
		r = n % d;
	end
endtask

`endif

//--- verification/div_unit_tb.sv
`timescale 1ns/100ps

module div_unit_tb;

	// Every division costs at most numer_width + 10 cycles including register traffic
	localparam int test_count      = 210;
	localparam int watchdog_cycles = test_count * (div_cfg_pkg::numer_width + 10) + 1000;

	logic                                clk;
	logic                                clr;
	logic                                wr_en;
	logic [div_regs_pkg::addr_width-1:0] addr;
	logic [div_regs_pkg::data_width-1:0] wdata;
	logic [div_regs_pkg::data_width-1:0] rdata;
	logic                                busy;
	logic                                done_flag;

	int   seed = 32'h94f3e5e6;
	logic done_prev = 1'b0;
	int   done_rises = 0;

	div_unit_top div_unit_top_i (
		.clk       (clk),
		.clr       (clr),
		.wr_en     (wr_en),
		.addr      (addr),
		.wdata     (wdata),
		.rdata     (rdata),
		.busy      (busy),
		.done_flag (done_flag)
	);

	`include "div_tb_tasks.svh"

	always #5 clk = ~clk;

	// Counts rising edges of the sticky done flag
	always @(posedge clk) begin
		if (done_flag && !done_prev) begin
			done_rises = done_rises + 1;
		end
		done_prev <= done_flag;
	end

	initial begin
		#(watchdog_cycles * 10);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$fatal(1);
	end

	task automatic wait_for_done(output int cycles);
		cycles = 0;
		while (done_flag !== 1'b1) begin
			if (cycles > div_cfg_pkg::numer_width + 10) begin
				$display("done_flag did not rise after a start");
				$display("Test failed");
				$fatal(1);
			end
			@(posedge clk);
			#1;
			cycles++;
		end
	endtask

	// Reads a register, checks it, then lines up again 1 ns after the next edge
	task automatic read_and_check(input string name,
			input logic [div_regs_pkg::addr_width-1:0] a,
			input logic [div_regs_pkg::data_width-1:0] expected);
		logic [div_regs_pkg::data_width-1:0] actual;
		reg_read(a, actual);
		check_value(name, expected, actual);
		@(posedge clk);
		#1;
	endtask

	task automatic divide_and_check(input string name,
			input logic [div_cfg_pkg::numer_width-1:0] n,
			input logic [div_cfg_pkg::denom_width-1:0] d);
		logic [div_cfg_pkg::numer_width-1:0] q_exp;
		logic [div_cfg_pkg::denom_width-1:0] r_exp;
		int                                  cycles;
		ref_div(n, d, q_exp, r_exp);
		reg_write(div_regs_pkg::addr_numer, n);
		reg_write(div_regs_pkg::addr_denom, d);
		reg_write(div_regs_pkg::addr_ctrl, 32'd1);
		wait_for_done(cycles);
		check_value({name, " latency"}, div_cfg_pkg::numer_width + 3, cycles);
		read_and_check({name, " quot"}, div_regs_pkg::addr_quot, q_exp);
		read_and_check({name, " rem"}, div_regs_pkg::addr_rem, r_exp);
	endtask

	initial begin
		logic [div_regs_pkg::data_width-1:0] n;
		logic [div_regs_pkg::data_width-1:0] d;
		logic [div_regs_pkg::data_width-1:0] q_exp;
		logic [div_regs_pkg::data_width-1:0] r_exp;
		logic [div_regs_pkg::data_width-1:0] r1;
		logic [div_regs_pkg::data_width-1:0] r2;
		int                                  cycles;
		int                                  rises_before;

		clk   = 1'b0;
		clr   = 1'b1;
		wr_en = 1'b0;
		addr  = '0;
		wdata = '0;
		repeat (3) @(posedge clk);
		#1;
		clr = 1'b0;

		check_value("reset busy", 32'd0, 32'(busy));
		check_value("reset done_flag", 32'd0, 32'(done_flag));
		read_and_check("reset status", div_regs_pkg::addr_status, 32'd0);
		read_and_check("reset quot", div_regs_pkg::addr_quot, 32'd0);
		read_and_check("reset rem", div_regs_pkg::addr_rem, 32'd0);

		n = $random(seed);
		d = $random(seed);
		reg_write(div_regs_pkg::addr_numer, n);
		reg_write(div_regs_pkg::addr_denom, d);
		read_and_check("numer readback", div_regs_pkg::addr_numer, n);
		read_and_check("denom readback", div_regs_pkg::addr_denom, d);

		// Cycle through random, smaller, larger and equal denominators
		for (int i = 0; i < 200; i++) begin
			r1 = $random(seed);
			r2 = $random(seed);
			case (i % 4)
				1: begin
					n = r1;
					d = (r1 >> r2[4:0]) | 32'd1;
				end
				2: begin
					n = r1 & 32'h7fff_ffff;
					d = n + 32'd1 + (r2 & 32'h0000_ffff);
				end
				3: begin
					n = r1 | 32'd1;
					d = n;
				end
				default: begin
					n = r1;
					d = r2;
				end
			endcase
			divide_and_check($sformatf("random %0d", i), n, d);
		end

		n = $random(seed);
		divide_and_check("divide by zero", n, 32'd0);
		read_and_check("divide by zero all ones", div_regs_pkg::addr_quot, 32'hffff_ffff);

		// Start requests and a new numerator while busy must not disturb the run
		// The last request lands on the edge where done arrives, while busy is still set
		n = $random(seed);
		d = ($random(seed) & 32'h0000_ffff) | 32'd1;
		ref_div(n, d, q_exp, r_exp);
		rises_before = done_rises;
		reg_write(div_regs_pkg::addr_numer, n);
		reg_write(div_regs_pkg::addr_denom, d);
		reg_write(div_regs_pkg::addr_ctrl, 32'd1);
		reg_write(div_regs_pkg::addr_ctrl, 32'd1);
		reg_write(div_regs_pkg::addr_numer, ~n);
		reg_write(div_regs_pkg::addr_ctrl, 32'd1);
		repeat (div_cfg_pkg::numer_width - 1) @(posedge clk);
		#1;
		check_value("busy start late busy", 32'd1, 32'(busy));
		reg_write(div_regs_pkg::addr_ctrl, 32'd1);
		wait_for_done(cycles);
		read_and_check("busy start quot", div_regs_pkg::addr_quot, q_exp);
		read_and_check("busy start rem", div_regs_pkg::addr_rem, r_exp);
		repeat (div_cfg_pkg::numer_width + 5) @(posedge clk);
		#1;
		check_value("busy start done rises", 32'd1, done_rises - rises_before);
		check_value("busy start idle", 32'd0, 32'(busy));

		n = $random(seed);
		d = $random(seed);
		ref_div(n, d, q_exp, r_exp);
		reg_write(div_regs_pkg::addr_numer, n);
		reg_write(div_regs_pkg::addr_denom, d);
		reg_write(div_regs_pkg::addr_ctrl, 32'd1);
		check_value("latency busy", 32'd1, 32'(busy));
		check_value("latency done cleared", 32'd0, 32'(done_flag));
		wait_for_done(cycles);
		check_value("latency cycles", div_cfg_pkg::numer_width + 3, cycles);
		read_and_check("latency quot", div_regs_pkg::addr_quot, q_exp);
		read_and_check("latency rem", div_regs_pkg::addr_rem, r_exp);

		$display("Test passed");
		$finish;
	end

endmodule

//--- div_unit.f
+incdir+include
verilog/div_cfg_pkg.sv
verilog/div_regs_pkg.sv
verilog/div_reg_block.sv
verilog/nonrestore_div.sv
verilog/div_unit_top.sv
verification/div_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the divider testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module div_unit_tb -f div_unit.f -o div_unit_sim &&
./obj_dir/div_unit_sim ||
{ echo "Simulation did not complete successfully"; exit 1; }
